// File: flist.f
+incdir+source
source/mem_pkg.sv
source/data_bram.sv
source/store_align.sv
source/load_extract.sv
source/retrieve_timer.sv
source/mem_access_fsm.sv
source/data_mem_unit.sv
verification/tb_clock_gen.sv
verification/tb_data_mem_unit.sv

// File: Makefile
TOP := tb_data_mem_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_data_mem_unit.sv
`include "mem_defines.svh"

module tb_data_mem_unit import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH      = `DMEM_DEPTH;
  localparam int WAIT       = `DMEM_WAIT_CYCLES;
  localparam int NUM_RANDOM = 200;

  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } vec_t;

  logic        clkb;
  logic        rstb;
  mem_req_t    req;
  logic        stall;
  logic        load_valid;
  logic [31:0] load_data;

  vec_t        vec_q[$];
  logic [7:0]  model_mem [4*DEPTH];
  int          seed = 32'hd73c_6e39;
  int          data_errors;
  int          stall_errors;
  int          valid_errors;
  int          cycles;
  int          max_cycles;

  tb_clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (5)
  ) u_tb_clock_gen (
    .clkb (clkb),
    .rstb (rstb)
  );

  data_mem_unit u_data_mem_unit (
    .clkb       (clkb),
    .rstb       (rstb),
    .req        (req),
    .stall      (stall),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  function automatic logic is_load_op(input mem_op_e op);
    return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  endfunction

  // first byte of the addressed word, index wraps over the depth
  function automatic int unsigned byte_base(input logic [31:0] addr);
    return ((addr >> 2) % DEPTH) * 4;
  endfunction

  task automatic model_store(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    int unsigned base;
    base = byte_base(addr);
    case (op)
      op_sb: begin
        model_mem[base + addr[1:0]] = data[7:0];
      end
      op_sh: begin
        model_mem[base + {addr[1], 1'b0}]     = data[7:0];
        model_mem[base + {addr[1], 1'b0} + 1] = data[15:8];
      end
      op_sw: begin
        for (int i = 0; i < 4; i++) begin
          model_mem[base + i] = data[8*i +: 8];
        end
      end
      default: begin
      end
    endcase
  endtask

  function automatic logic [31:0] model_load(input mem_op_e op, input logic [31:0] addr);
    int unsigned base;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    base = byte_base(addr);
    b = model_mem[base + addr[1:0]];
    h = {model_mem[base + {addr[1], 1'b0} + 1], model_mem[base + {addr[1], 1'b0}]};
    w = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    case (op)
      op_lb:   return {{24{b[7]}}, b};
      op_lh:   return {{16{h[15]}}, h};
      op_lw:   return w;
      op_lbu:  return {24'b0, b};
      op_lhu:  return {16'b0, h};
      default: return 32'h0;
    endcase
  endfunction

  task automatic check_load_data(input mem_op_e op, input logic [31:0] exp,
                                 input logic [31:0] act);
    if (act !== exp) begin
      data_errors++;
      $display("mismatch at %0t ns: %s addr %08h load data expected %08h, got %08h",
               $time, op.name(), req.addr.raw, exp, act);
    end
  endtask

  task automatic check_stall(input int exp, input int act);
    if (act != exp) begin
      stall_errors++;
      $display("mismatch at %0t ns: stall high for %0d cycles, expected %0d",
               $time, act, exp);
    end
  endtask

  task automatic check_valid(input int exp, input int act);
    if (act != exp) begin
      valid_errors++;
      $display("mismatch at %0t ns: load_valid high for %0d cycles, expected %0d",
               $time, act, exp);
    end
  endtask

  function automatic void add_vec(input mem_op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [31:0] exp);
    vec_t v;
    v.op   = op;
    v.addr = addr;
    v.data = data;
    v.exp  = exp;
    vec_q.push_back(v);
  endfunction

  // drive on the falling edge, sample 1 ns later each cycle until done
  task automatic apply_op(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    int          stall_cycles;
    int          valid_cycles;
    logic [31:0] got;
    logic        done;
    stall_cycles = 0;
    valid_cycles = 0;
    got          = 32'h0;
    done         = 1'b0;
    @(negedge clkb);
    req.op       = op;
    req.addr.raw = addr;
    req.data     = data;
    #1;
    while (!done) begin
      if (stall) begin
        stall_cycles++;
      end
      if (load_valid) begin
        valid_cycles++;
      end
      got = load_data;
      if (!is_load_op(op) || load_valid) begin
        done = 1'b1;
      end else begin
        @(negedge clkb);
        #1;
      end
    end
    // the strobe must be gone one edge after its pulse
    if (is_load_op(op)) begin
      @(posedge clkb);
      #1;
      if (load_valid) begin
        valid_cycles++;
      end
    end
    check_stall(is_load_op(op) ? WAIT + 2 : 0, stall_cycles);
    check_valid(is_load_op(op) ? 1 : 0, valid_cycles);
    check_load_data(op, is_load_op(op) ? exp : 32'h0, got);
    model_store(op, addr, data);
  endtask

  // run limit from the test length
  always @(posedge clkb) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("error: run stopped after %0d cycles, a load never completed", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
    req          = '0;
    data_errors  = 0;
    stall_errors = 0;
    valid_errors = 0;
    cycles       = 0;
    for (int i = 0; i < 4 * DEPTH; i++) begin
      model_mem[i] = 8'h00;
    end

    // words, wrap past the depth
    add_vec(op_none, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    add_vec(op_sw,   32'h0000_0010, 32'h1234_5678, 32'h0000_0000);
    add_vec(op_sw,   32'h0000_0014, 32'hcafe_f00d, 32'h0000_0000);
    add_vec(op_lw,   32'h0000_0010, 32'h0000_0000, 32'h1234_5678);
    add_vec(op_lw,   32'h0000_0014, 32'h0000_0000, 32'hcafe_f00d);
    add_vec(op_sw,   32'h0000_1010, 32'ha5a5_0f0f, 32'h0000_0000);
    add_vec(op_lw,   32'h0000_0010, 32'h0000_0000, 32'ha5a5_0f0f);
    add_vec(op_lw,   32'h0000_2014, 32'h0000_0000, 32'hcafe_f00d);
    // byte and halfword merges
    add_vec(op_sw,   32'h0000_0020, 32'h1122_3344, 32'h0000_0000);
    add_vec(op_sb,   32'h0000_0020, 32'hffff_ffaa, 32'h0000_0000);
    add_vec(op_sb,   32'h0000_0021, 32'h0000_00bb, 32'h0000_0000);
    add_vec(op_sb,   32'h0000_0022, 32'h1234_56cc, 32'h0000_0000);
    add_vec(op_sb,   32'h0000_0023, 32'h0000_00dd, 32'h0000_0000);
    add_vec(op_lw,   32'h0000_0020, 32'h0000_0000, 32'hddcc_bbaa);
    add_vec(op_sh,   32'h0000_0020, 32'h1234_beef, 32'h0000_0000);
    add_vec(op_sh,   32'h0000_0022, 32'h5678_7e01, 32'h0000_0000);
    add_vec(op_lw,   32'h0000_0020, 32'h0000_0000, 32'h7e01_beef);
    add_vec(op_sh,   32'h0000_0021, 32'h0000_8421, 32'h0000_0000);
    add_vec(op_sh,   32'h0000_0023, 32'h0000_00c3, 32'h0000_0000);
    add_vec(op_lw,   32'h0000_0020, 32'h0000_0000, 32'h00c3_8421);
    // sign and zero extension at every offset
    add_vec(op_sw,   32'h0000_0030, 32'h7f80_01fe, 32'h0000_0000);
    add_vec(op_lb,   32'h0000_0030, 32'h0000_0000, 32'hffff_fffe);
    add_vec(op_lb,   32'h0000_0031, 32'h0000_0000, 32'h0000_0001);
    add_vec(op_lb,   32'h0000_0032, 32'h0000_0000, 32'hffff_ff80);
    add_vec(op_lb,   32'h0000_0033, 32'h0000_0000, 32'h0000_007f);
    add_vec(op_lbu,  32'h0000_0030, 32'h0000_0000, 32'h0000_00fe);
    add_vec(op_lbu,  32'h0000_0031, 32'h0000_0000, 32'h0000_0001);
    add_vec(op_lbu,  32'h0000_0032, 32'h0000_0000, 32'h0000_0080);
    add_vec(op_lbu,  32'h0000_0033, 32'h0000_0000, 32'h0000_007f);
    add_vec(op_lh,   32'h0000_0031, 32'h0000_0000, 32'h0000_01fe);
    add_vec(op_lh,   32'h0000_0032, 32'h0000_0000, 32'h0000_7f80);
    add_vec(op_lhu,  32'h0000_0030, 32'h0000_0000, 32'h0000_01fe);
    add_vec(op_lhu,  32'h0000_0033, 32'h0000_0000, 32'h0000_7f80);
    add_vec(op_sw,   32'h0000_0034, 32'h8001_ff7e, 32'h0000_0000);
    add_vec(op_lh,   32'h0000_0034, 32'h0000_0000, 32'hffff_ff7e);
    add_vec(op_lh,   32'h0000_0037, 32'h0000_0000, 32'hffff_8001);
    add_vec(op_lhu,  32'h0000_0035, 32'h0000_0000, 32'h0000_ff7e);
    add_vec(op_lhu,  32'h0000_0036, 32'h0000_0000, 32'h0000_8001);
    add_vec(op_lb,   32'h0000_0035, 32'h0000_0000, 32'hffff_ffff);
    add_vec(op_none, 32'h0000_0034, 32'h0000_0000, 32'h0000_0000);

    max_cycles = 5 + (vec_q.size() + NUM_RANDOM) * (WAIT + 4) + 50;

    // quiet outputs while reset is held
    repeat (4) begin
      @(negedge clkb);
      #1;
      check_stall(0, stall);
      check_valid(0, load_valid);
    end
    wait (rstb == 1'b0);
    repeat (3) begin
      apply_op(op_none, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    end

    foreach (vec_q[i]) begin
      apply_op(vec_q[i].op, vec_q[i].addr, vec_q[i].data, vec_q[i].exp);
    end

    // mixed traffic, some addresses wrap
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op   = mem_op_e'(4'(($unsigned($random(seed)) % 8) + 1));
      addr = $random(seed) & 32'h0000_307f;
      data = $random(seed);
      apply_op(op, addr, data, model_load(op, addr));
    end
    apply_op(op_none, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);

    $display("errors: load data %0d, stall %0d, load valid %0d",
             data_errors, stall_errors, valid_errors);
    if (data_errors + stall_errors + valid_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clkb,
  output logic rstb
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clkb = 1'b0;
    forever #(PERIOD / 2) clkb = ~clkb;
  end

  // reset held over the first edges, released on a falling edge
  initial begin
    rstb = 1'b1;
    repeat (RESET_CYCLES) @(posedge clkb);
    @(negedge clkb);
    rstb = 1'b0;
  end

endmodule

// File: source/data_mem_unit.sv
`include "mem_defines.svh"

module data_mem_unit import mem_pkg::*; (
  input  logic        clkb,
  input  logic        rstb,
  input  mem_req_t    req,
  output logic        stall,
  output logic        load_valid,
  output logic [31:0] load_data
);

  logic                   store;
  bram_wr_t               wr;
  logic                   timer_start;
  logic                   timer_done;
  logic                   rd_en;
  logic                   ram_en;
  logic [`DMEM_IDX_W-1:0] ram_idx;
  logic [31:0]            rd_word;

  // upper index bits dropped, addresses wrap over the depth
  assign ram_idx = req.addr.word.idx[`DMEM_IDX_W-1:0];
  assign ram_en  = store | rd_en;

  mem_access_fsm u_mem_access_fsm (
    .clkb        (clkb),
    .rstb        (rstb),
    .op          (req.op),
    .timer_done  (timer_done),
    .timer_start (timer_start),
    .rd_en       (rd_en),
    .stall       (stall),
    .load_valid  (load_valid)
  );

  retrieve_timer u_retrieve_timer (
    .clkb  (clkb),
    .rstb  (rstb),
    .start (timer_start),
    .done  (timer_done)
  );

  store_align u_store_align (
    .req   (req),
    .store (store),
    .wr    (wr)
  );

  data_bram #(
    .DEPTH (`DMEM_DEPTH)
  ) u_data_bram (
    .clkb    (clkb),
    .en      (ram_en),
    .idx     (ram_idx),
    .wr      (wr),
    .rd_word (rd_word)
  );

  // loads never carry lane enables, so a read enable always reads
  load_extract u_load_extract (
    .op        (req.op),
    .byte_off  (req.addr.word.off),
    .rd_word   (rd_word),
    .valid     (load_valid),
    .load_data (load_data)
  );

endmodule

// File: source/mem_access_fsm.sv
`include "mem_defines.svh"

module mem_access_fsm import mem_pkg::*; (
  input  logic    clkb,
  input  logic    rstb,
  input  mem_op_e op,
  input  logic    timer_done,
  output logic    timer_start,
  output logic    rd_en,
  output logic    stall,
  output logic    load_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_read,
    st_resp
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   is_load;
  logic   is_store;

  assign is_load  = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  assign is_store = op inside {op_sb, op_sh, op_sw};

  always_ff @(posedge clkb) begin
    if (rstb) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt   = state;
    timer_start = 1'b0;
    rd_en       = 1'b0;
    load_valid  = 1'b0;
    case (state)
      st_idle: begin
        if (is_load) begin
          timer_start = 1'b1;
          // zero wait goes straight to the read
          if (timer_done) begin
            rd_en     = 1'b1;
            state_nxt = st_read;
          end else begin
            state_nxt = st_wait;
          end
        end
      end
      st_wait: begin
        if (timer_done) begin
          rd_en     = 1'b1;
          state_nxt = st_read;
        end
      end
      st_read: begin
        // RAM word lands this cycle
        state_nxt = st_resp;
      end
      default: begin
        load_valid = 1'b1;
        state_nxt  = st_idle;
      end
    endcase
  end

  // stall drops in the response cycle
  assign stall = (state == st_idle && is_load) || state == st_wait || state == st_read;

  // valid strobe trails the timer start by the whole wait plus read and response
  a_valid_after_wait: assert property (@(posedge clkb) disable iff (rstb)
    load_valid |-> $past(timer_start, `DMEM_WAIT_CYCLES + 2))
    else $error("load_valid not %0d cycles after the timer start", `DMEM_WAIT_CYCLES + 2);

  // pipeline must hold the operation while stalled
  a_op_held: assert property (@(posedge clkb) disable iff (rstb)
    stall |=> $stable(op))
    else $error("operation changed under stall");

  // stores only arrive when no load is in flight
  a_no_store_in_load: assert property (@(posedge clkb) disable iff (rstb)
    (state != st_idle) |-> !is_store)
    else $error("store presented during an outstanding load");

endmodule

// File: source/retrieve_timer.sv
`include "mem_defines.svh"

module retrieve_timer (
  input  logic clkb,
  input  logic rstb,
  input  logic start,
  output logic done
);

  localparam int WAIT_CYCLES = `DMEM_WAIT_CYCLES;
  localparam int CNT_W = (WAIT_CYCLES < 2) ? 1 : $clog2(WAIT_CYCLES + 1);

  // zero means idle, otherwise cycles left including the current one
  logic [CNT_W-1:0] count;

  always_ff @(posedge clkb) begin
    if (rstb) begin
      count <= '0;
    end else if (start) begin
      count <= CNT_W'(WAIT_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // last count is the expiry cycle
  // with no wait the start itself counts as expiry
  assign done = (WAIT_CYCLES == 0) ? start : (count == CNT_W'(1));

endmodule

// File: source/load_extract.sv
module load_extract import mem_pkg::*; (
  input  mem_op_e     op,
  input  logic [1:0]  byte_off,
  input  logic [31:0] rd_word,
  input  logic        valid,
  output logic [31:0] load_data
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  always_comb begin
    case (byte_off)
      2'd0:    sel_byte = rd_word[7:0];
      2'd1:    sel_byte = rd_word[15:8];
      2'd2:    sel_byte = rd_word[23:16];
      default: sel_byte = rd_word[31:24];
    endcase
  end

  // halfword by bit 1 only
  assign sel_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    load_data = 32'b0;
    // result only shown in the valid cycle
    if (valid) begin
      case (op)
        op_lb: begin
          load_data = {{24{sel_byte[7]}}, sel_byte};
        end
        op_lh: begin
          load_data = {{16{sel_half[15]}}, sel_half};
        end
        op_lw: begin
          load_data = rd_word;
        end
        op_lbu: begin
          load_data = {24'b0, sel_byte};
        end
        op_lhu: begin
          load_data = {16'b0, sel_half};
        end
        default: begin
          load_data = 32'b0;
        end
      endcase
    end
  end

endmodule

// File: source/store_align.sv
module store_align import mem_pkg::*; (
  input  mem_req_t req,
  output logic     store,
  output bram_wr_t wr
);

  logic [1:0] off;

  assign off   = req.addr.word.off;
  assign store = (req.op == op_sb) || (req.op == op_sh) || (req.op == op_sw);

  always_comb begin
    wr = '0;
    case (req.op)
      op_sb: begin
        // byte goes to the lane picked by the offset
        wr.be   = 4'b0001 << off;
        wr.data = {24'b0, req.data[7:0]} << {off, 3'b000};
      end
      op_sh: begin
        // bit 0 dropped, misaligned halfwords land aligned down
        if (req.addr.raw[1]) begin
          wr.be   = 4'b1100;
          wr.data = {req.data[15:0], 16'b0};
        end else begin
          wr.be   = 4'b0011;
          wr.data = {16'b0, req.data[15:0]};
        end
      end
      op_sw: begin
        wr.be   = 4'b1111;
        wr.data = req.data;
      end
      default: begin
        wr = '0;
      end
    endcase

    // enabled lanes must carry the store data
    if (req.op == op_sb) begin
      a_sb_onehot: assert ($onehot(wr.be) && wr.be[off] &&
                           wr.data[8*off +: 8] == req.data[7:0])
        else $error("sb lanes and data disagree: be %b data %h", wr.be, wr.data);
    end
    if (req.op == op_sh) begin
      a_sh_pair: assert ((wr.be == 4'b0011 || wr.be == 4'b1100) && wr.be[off] &&
                         wr.data[{off[1], 4'b0000} +: 16] == req.data[15:0])
        else $error("sh lanes and data disagree: be %b data %h", wr.be, wr.data);
    end
  end

endmodule

// File: source/data_bram.sv
`include "mem_defines.svh"

module data_bram import mem_pkg::*; #(
  parameter int DEPTH = `DMEM_DEPTH
) (
  input  logic                   clkb,
  input  logic                   en,
  input  logic [`DMEM_IDX_W-1:0] idx,
  input  bram_wr_t               wr,
  output logic [31:0]            rd_word
);

  logic [31:0] mem [DEPTH];

  // memory comes up cleared, reset never touches it
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'h0000_0000;
    end
  end

  // one access per enabled edge
  // any lane enable means a write, none means a read
  always_ff @(posedge clkb) begin
    if (en) begin
      if (wr.be == 4'b0000) begin
        rd_word <= mem[idx];
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (wr.be[b]) begin
            mem[idx][8*b +: 8] <= wr.data[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

  // memory operation from the pipeline
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_e;

  // word view of a byte address
  typedef struct packed {
    logic [29:0] idx;
    logic [1:0]  off;
  } mem_word_addr_t;

  // same 32 bits, raw byte address or word index plus byte offset
  typedef union packed {
    logic [31:0]    raw;
    mem_word_addr_t word;
  } mem_addr_u;

  // one operation as presented by the pipeline
  typedef struct packed {
    mem_op_e     op;
    mem_addr_u   addr;
    logic [31:0] data;
  } mem_req_t;

  // RAM write port, lane enables and lane-placed data
  typedef struct packed {
    logic [3:0]  be;
    logic [31:0] data;
  } bram_wr_t;

endpackage

// File: source/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data memory geometry
// depth must stay at 2**DMEM_IDX_W so that the word index wraps cleanly
`define DMEM_DEPTH 1024
`define DMEM_IDX_W 10

// retrieve latency of a load, in cycles before the read is issued
// zero means the read goes out in the same cycle the load arrives
`define DMEM_WAIT_CYCLES 2

`endif
